/* hw/izh_config.svh */
// izhikevich array configuration: sizes, 2.16 fixed-point constants, lfsr seed and taps
`ifndef IZH_CONFIG_SVH
`define IZH_CONFIG_SVH

//////////////////////////////////////////////////
// array size
`define IZH_IDX_W      4                    // neuron index bits
`define IZH_NEURONS    16                   // one ram word per neuron

//////////////////////////////////////////////////
// datapath, 2.16 two's complement
`define IZH_FIX_W      18                   // datapath word
`define IZH_C14        18'sh1_6666          // 1.4 constant term
`define IZH_V_THRESH   18'sh0_4CCC          // 0.30 spike threshold
`define IZH_V_INIT     18'sh3_4CCD          // v after init, about -0.70
`define IZH_U_INIT     18'sh3_CCCD          // u after init, about -0.20

//////////////////////////////////////////////////
// noise source
`define IZH_LFSR_SEED  128'h3333_3333_3333_3333_3333_3333_3333_32ff
// feedback mask, bits 127 125 100 98 set
`define IZH_LFSR_TAPS  128'hA000_0014_0000_0000_0000_0000_0000_0000

//////////////////////////////////////////////////
// register block
`define IZH_AXI_AW     5                    // byte address, 8 word slots

`endif

/* hw/izh_pkg.sv */
// izhikevich array types shared by the datapath, the rams and the testbench
`include "izh_config.svh"

package izh_pkg;

	// one fixed-point word, 2 integer bits and 16 fraction bits
	typedef logic signed [`IZH_FIX_W-1:0] fix18_t;

	// neuron address into both state rams
	typedef logic [`IZH_IDX_W-1:0] idx_t;

	// shift amount standing in for a multiply
	// a and b of the model, and the epsp time constant tau
	typedef logic [3:0] shift_t;

	// membrane state of one neuron
	// v is the potential, u the recovery variable
	typedef struct packed
	{
		fix18_t v;   // upper half of the word
		fix18_t u;   // lower half
	} vu_state_t;

	// the epsp ram holds a bare fix18_t, no struct needed

endpackage

/* hw/izh_csr.sv */
// izhikevich array register block, axi4-lite slave for run control, neuron parameters and spike count
`timescale 1ns/100ps
`include "izh_config.svh"

module izh_csr (
	input  logic                   readClock,
	input  logic                   rst_n,
	// axi4-lite write side
	input  logic [`IZH_AXI_AW-1:0] awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [31:0]            wdata,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	// axi4-lite read side
	input  logic [`IZH_AXI_AW-1:0] araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	// to the datapath
	output logic                   run,
	output izh_pkg::fix18_t        bias,
	output izh_pkg::fix18_t        drive_weight,
	output izh_pkg::shift_t        a,
	output izh_pkg::shift_t        b,
	output izh_pkg::shift_t        tau,
	output izh_pkg::fix18_t        c,
	output izh_pkg::fix18_t        d,
	// from the sequencer
	input  logic                   sweep_done,
	input  logic [`IZH_IDX_W:0]    spike_total
);
	import izh_pkg::*;

	// word offsets, awaddr[4:2]
	localparam logic [2:0] REG_CTRL   = 3'd0;
	localparam logic [2:0] REG_BIAS   = 3'd1;
	localparam logic [2:0] REG_WEIGHT = 3'd2;
	localparam logic [2:0] REG_SHIFTS = 3'd3;
	localparam logic [2:0] REG_C      = 3'd4;
	localparam logic [2:0] REG_D      = 3'd5;
	localparam logic [2:0] REG_LAST   = 3'd6;

	// fast spiking cell after reset
	localparam fix18_t DEF_WEIGHT = 18'sh0_1000;   // 1/16
	localparam fix18_t DEF_C      = 18'sh3_599A;   // -0.65
	localparam fix18_t DEF_D      = 18'sh0_147A;   // 0.08
	localparam shift_t DEF_A      = 4'd3;          // 0.125
	localparam shift_t DEF_B      = 4'd2;          // 0.25
	localparam shift_t DEF_TAU    = 4'd2;

	logic                wr_ready;      // shared by aw and w
	logic                ar_ready;
	logic                wr_fire;
	logic                rd_fire;
	logic [31:0]         rd_word;
	logic [`IZH_IDX_W:0] last_spikes;   // count of the last full sweep

	assign awready = wr_ready;
	assign wready  = wr_ready;
	assign arready = ar_ready;
	assign bresp   = 2'b00;   // always okay
	assign rresp   = 2'b00;
	assign wr_fire = wr_ready & awvalid & wvalid;
	assign rd_fire = ar_ready & arvalid;

	//////////////////////////////////////////////////
	// handshakes
	always_ff @(posedge readClock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ready <= 1'b0;
			bvalid   <= 1'b0;
			ar_ready <= 1'b0;
			rvalid   <= 1'b0;
		end
		else
		begin
			// one-cycle ready pulse once aw and w are both up, held off by a pending b
			wr_ready <= ~wr_ready & awvalid & wvalid & ~bvalid;
			ar_ready <= ~ar_ready & arvalid & ~rvalid;   // one read in flight
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// register file, full-word writes
	always_ff @(posedge readClock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run          <= 1'b0;
			bias         <= '0;   // no drive
			drive_weight <= DEF_WEIGHT;
			a            <= DEF_A;
			b            <= DEF_B;
			tau          <= DEF_TAU;
			c            <= DEF_C;
			d            <= DEF_D;
			last_spikes  <= '0;
		end
		else
		begin
			if (wr_fire)
			begin
				case (awaddr[`IZH_AXI_AW-1:2])
					REG_CTRL:   run          <= wdata[0];
					REG_BIAS:   bias         <= wdata[`IZH_FIX_W-1:0];
					REG_WEIGHT: drive_weight <= wdata[`IZH_FIX_W-1:0];
					REG_SHIFTS:
					begin
						a   <= wdata[3:0];
						b   <= wdata[7:4];
						tau <= wdata[11:8];
					end
					REG_C:      c            <= wdata[`IZH_FIX_W-1:0];
					REG_D:      d            <= wdata[`IZH_FIX_W-1:0];
					default:    ;   // last_spikes and holes ignore writes
				endcase
			end
			if (sweep_done)
				last_spikes <= spike_total;   // snapshot at end of sweep
		end
	end

	// read decode, holes return zero
	always_comb
	begin
		rd_word = '0;
		case (araddr[`IZH_AXI_AW-1:2])
			REG_CTRL:   rd_word = {31'd0, run};
			REG_BIAS:   rd_word = {{(32-`IZH_FIX_W){1'b0}}, bias};
			REG_WEIGHT: rd_word = {{(32-`IZH_FIX_W){1'b0}}, drive_weight};
			REG_SHIFTS: rd_word = {20'd0, tau, b, a};
			REG_C:      rd_word = {{(32-`IZH_FIX_W){1'b0}}, c};
			REG_D:      rd_word = {{(32-`IZH_FIX_W){1'b0}}, d};
			REG_LAST:   rd_word = {{(31-`IZH_IDX_W){1'b0}}, last_spikes};
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge readClock)
	begin
		if (rd_fire)
			rdata <= rd_word;   // held with rvalid
	end

endmodule

/* hw/state_ram.sv */
// neuron state ram, one write port and one synchronous read port, payload set by type parameter
`timescale 1ns/100ps
`include "izh_config.svh"

module state_ram #(
	parameter type payload_t = izh_pkg::fix18_t   // vu_state_t or fix18_t
) (
	input  logic          readClock,
	input  izh_pkg::idx_t rd_idx,     // neuron being fetched
	output payload_t      rd_data,    // valid one cycle after rd_idx
	input  logic          wr_en,
	input  izh_pkg::idx_t wr_idx,     // neuron being written back
	input  payload_t      wr_data
);
	import izh_pkg::*;

	// one word per neuron, filled by the init sweep
	payload_t mem [`IZH_NEURONS];

	always_ff @(posedge readClock)
	begin
		if (wr_en)
			mem[wr_idx] <= wr_data;   // write-back of the previous neuron
		rd_data <= mem[rd_idx];       // old data on a same-address collision
	end

endmodule

/* hw/poisson_drive.sv */
// stochastic input drive, 128-bit lfsr compared against a bias once per neuron step
`timescale 1ns/100ps
`include "izh_config.svh"

module poisson_drive (
	input  logic            readClock,
	input  logic            rst_n,
	input  logic            init,    // array idle, hold the seed
	input  logic            step,    // one neuron written back
	input  izh_pkg::fix18_t bias,    // firing probability, 0x10000 and up is always on
	output logic            drive
);
	import izh_pkg::*;

	logic [127:0] lfsr;
	logic         fb;       // xor of the taps
	fix18_t       sample;   // low 16 bits as a positive 2.16 value

	assign fb     = ^(lfsr & `IZH_LFSR_TAPS);
	assign sample = fix18_t'({2'b00, lfsr[15:0]});
	assign drive  = (sample < bias);   // current lfsr value, before this step's shift

	always_ff @(posedge readClock or negedge rst_n)
	begin
		if (!rst_n)
			lfsr <= `IZH_LFSR_SEED;
		else if (init)
			lfsr <= `IZH_LFSR_SEED;   // every run replays the same sequence
		else if (step)
			lfsr <= {lfsr[126:0], fb};
	end

endmodule

/* hw/neuron_sweep.sv */
// neuron index sequencer, read to write-back pipeline and per-sweep spike count
`timescale 1ns/100ps
`include "izh_config.svh"

module neuron_sweep (
	input  logic                readClock,
	input  logic                rst_n,
	input  logic                run,
	input  logic                spike,          // from the neuron being written
	output izh_pkg::idx_t       rd_idx,
	output izh_pkg::idx_t       wr_idx,
	output logic                wr_en,
	output logic                init,           // write stage stores reset state
	output logic                sweep_done,     // one pulse per completed sweep
	output logic [`IZH_IDX_W:0] spike_total     // valid with sweep_done
);
	import izh_pkg::*;

	localparam idx_t LAST_IDX = idx_t'(`IZH_NEURONS - 1);

	logic                run_q;     // run as seen by the write stage
	logic                run_rise;
	logic                compute;   // real update being written
	idx_t                cnt;       // next read index
	logic [`IZH_IDX_W:0] acc;       // running spike sum

	assign run_rise = run & ~run_q;
	assign rd_idx   = run_rise ? '0 : cnt;   // restart the sweep at neuron 0
	assign init     = ~run_q;
	assign compute  = wr_en & ~init;

	always_ff @(posedge readClock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run_q  <= 1'b0;
			cnt    <= '0;
			wr_idx <= '0;
			wr_en  <= 1'b0;   // no read issued yet
		end
		else
		begin
			run_q  <= run;
			cnt    <= rd_idx + 1'b1;   // wraps 15 to 0
			wr_idx <= rd_idx;          // ram data arrives with this index
			wr_en  <= 1'b1;            // swept every cycle, running or not
		end
	end

	//////////////////////////////////////////////////
	// spike accumulation
	always_ff @(posedge readClock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			acc         <= '0;
			spike_total <= '0;
			sweep_done  <= 1'b0;
		end
		else
		begin
			sweep_done <= 1'b0;
			if (compute)
			begin
				if (wr_idx == '0)
					acc <= (`IZH_IDX_W+1)'(spike);   // first neuron restarts the sum
				else
					acc <= acc + spike;
				if (wr_idx == LAST_IDX && run)
				begin
					sweep_done  <= 1'b1;
					spike_total <= acc + spike;
				end
			end
		end
	end

endmodule

/* hw/izh_update.sv */
// izhikevich neuron update, 2.16 fixed point, with low-pass filtered input current
`timescale 1ns/100ps
`include "izh_config.svh"

module izh_update (
	input  logic               init,           // emit the reset state
	input  izh_pkg::vu_state_t state_in,       // from the vu ram
	input  izh_pkg::fix18_t    epsp_in,        // from the epsp ram
	input  logic               drive,          // poisson input this step
	input  izh_pkg::fix18_t    drive_weight,
	input  izh_pkg::shift_t    a,
	input  izh_pkg::shift_t    b,
	input  izh_pkg::shift_t    tau,
	input  izh_pkg::fix18_t    c,              // v after a spike
	input  izh_pkg::fix18_t    d,              // u increment after a spike
	output izh_pkg::vu_state_t state_out,
	output izh_pkg::fix18_t    epsp_out,
	output logic               spike
);
	import izh_pkg::*;

	localparam int W = `IZH_FIX_W;

	fix18_t              v;
	fix18_t              u;
	fix18_t              i_in;       // input current
	fix18_t              epsp_neg;
	fix18_t              epsp_new;
	logic signed [2*W-1:0] v_prod;   // full v*v
	fix18_t              v_sq;       // v*v back in 2.16
	fix18_t              v_new;
	fix18_t              v_b;        // b*v
	fix18_t              u_diff;
	fix18_t              u_new;
	fix18_t              u_jump;
	logic                fire;

	assign v = state_in.v;
	assign u = state_in.u;

	//////////////////////////////////////////////////
	// input filter
	// epsp' = epsp + (I - epsp)/2^tau, I added unscaled
	assign i_in     = drive ? drive_weight : '0;
	assign epsp_neg = -epsp_in;
	assign epsp_new = epsp_in + (epsp_neg >>> tau) + i_in;

	//////////////////////////////////////////////////
	// membrane potential
	assign v_prod = v * v;                              // signed 36-bit product
	assign v_sq   = {v_prod[2*W-1], v_prod[2*W-4:W-2]};  // sign plus bits 32:16
	assign fire   = (v > `IZH_V_THRESH);

	// v' = v + 4v^2 + 5v + 1.4 - u + epsp, old epsp used
	assign v_new = v + (v_sq <<< 2) + v + (v <<< 2) + `IZH_C14 - u + epsp_in;

	// recovery, u' = u + a(bv - u) with a and b as shifts
	assign v_b    = v >>> b;
	assign u_diff = v_b - u;
	assign u_new  = u + (u_diff >>> a);
	assign u_jump = u + d;   // after-spike bump

	//////////////////////////////////////////////////
	// next state select
	always_comb
	begin
		if (init)
		begin
			state_out.v = `IZH_V_INIT;   // resting cell
			state_out.u = `IZH_U_INIT;
		end
		else if (fire)
		begin
			state_out.v = c;
			state_out.u = u_jump;
		end
		else
		begin
			state_out.v = v_new;
			state_out.u = u_new;
		end
	end

	assign epsp_out = init ? '0 : epsp_new;
	assign spike    = fire & ~init;   // no spikes while initialising

endmodule

/* hw/izh_array_top.sv */
// izhikevich array top, register block, sequencer, noise drive, update datapath and state rams
`timescale 1ns/100ps
`include "izh_config.svh"

module izh_array_top (
	input  logic                   readClock,
	input  logic                   rst_n,
	// axi4-lite slave
	input  logic [`IZH_AXI_AW-1:0] awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [31:0]            wdata,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  logic [`IZH_AXI_AW-1:0] araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	// sweep status
	output logic                   sweep_done,
	output logic [`IZH_IDX_W:0]    spike_total
);
	import izh_pkg::*;

	logic      run;
	fix18_t    bias;
	fix18_t    drive_weight;
	shift_t    a;
	shift_t    b;
	shift_t    tau;
	fix18_t    c;
	fix18_t    d;
	idx_t      rd_idx;
	idx_t      wr_idx;
	logic      wr_en;      // also the lfsr step
	logic      init;
	logic      drive;
	logic      spike;
	vu_state_t vu_rd;
	vu_state_t vu_wr;
	fix18_t    epsp_rd;
	fix18_t    epsp_wr;

	//////////////////////////////////////////////////
	// control
	izh_csr u_izh_csr (
		.readClock(readClock), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.run(run), .bias(bias), .drive_weight(drive_weight),
		.a(a), .b(b), .tau(tau), .c(c), .d(d),
		.sweep_done(sweep_done), .spike_total(spike_total)
	);

	neuron_sweep u_neuron_sweep (
		.readClock(readClock), .rst_n(rst_n), .run(run), .spike(spike),
		.rd_idx(rd_idx), .wr_idx(wr_idx), .wr_en(wr_en), .init(init),
		.sweep_done(sweep_done), .spike_total(spike_total)
	);

	poisson_drive u_poisson_drive (
		.readClock(readClock), .rst_n(rst_n), .init(init),
		.step(wr_en), .bias(bias), .drive(drive)
	);

	//////////////////////////////////////////////////
	// datapath and state
	izh_update u_izh_update (
		.init(init), .state_in(vu_rd), .epsp_in(epsp_rd), .drive(drive),
		.drive_weight(drive_weight), .a(a), .b(b), .tau(tau), .c(c), .d(d),
		.state_out(vu_wr), .epsp_out(epsp_wr), .spike(spike)
	);

	state_ram #(.payload_t(vu_state_t)) u_vu_ram (
		.readClock(readClock), .rd_idx(rd_idx), .rd_data(vu_rd),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(vu_wr)
	);

	state_ram #(.payload_t(fix18_t)) u_epsp_ram (
		.readClock(readClock), .rd_idx(rd_idx), .rd_data(epsp_rd),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(epsp_wr)
	);

endmodule

/* verif/izh_tb_model.svh */
// izhikevich array reference model, 16 neurons, epsp filter and the noise lfsr, stepped in index order

fix18_t       mdl_v    [`IZH_NEURONS];   // membrane potential per neuron
fix18_t       mdl_u    [`IZH_NEURONS];   // recovery variable
fix18_t       mdl_epsp [`IZH_NEURONS];   // filtered input current
logic [127:0] mdl_lfsr;

// shift left by one, tap xor enters at bit 0
function automatic logic [127:0] lfsr_advance(input logic [127:0] cur);
	logic fb;
	fb = cur[127] ^ cur[125] ^ cur[100] ^ cur[98];
	return {cur[126:0], fb};
endfunction

// drive when the low 16 bits, taken as unsigned, sit below the signed bias
function automatic logic drive_bit(input logic [127:0] cur, input fix18_t bias);
	return (int'(cur[15:0]) < int'(bias));
endfunction

// low-pass filter, leak of epsp/2^tau then the new current on top
function automatic fix18_t epsp_step(input fix18_t epsp, input fix18_t i_in, input shift_t tau);
	fix18_t neg;
	fix18_t leak;
	neg  = -epsp;
	leak = neg >>> tau;
	return epsp + leak + i_in;
endfunction

// state after the init sweep
task automatic model_reset();
	for (int k = 0; k < `IZH_NEURONS; k++)
	begin
		mdl_v[k]    = `IZH_V_INIT;
		mdl_u[k]    = `IZH_U_INIT;
		mdl_epsp[k] = '0;
	end
	mdl_lfsr = `IZH_LFSR_SEED;   // every run starts from the seed
endtask

// one full sweep, neuron 0 first, returns the number that fired
task automatic model_sweep(
	input  fix18_t      bias,
	input  fix18_t      weight,
	input  logic [31:0] shifts,   // a 3:0, b 7:4, tau 11:8
	input  fix18_t      c,
	input  fix18_t      d,
	output int          spikes
);
	fix18_t             v;
	fix18_t             u;
	fix18_t             i_in;
	fix18_t             sq;     // v^2 in 2.16
	fix18_t             diff;
	logic signed [35:0] prod;
	spikes = 0;
	for (int k = 0; k < `IZH_NEURONS; k++)
	begin
		v    = mdl_v[k];
		u    = mdl_u[k];
		i_in = drive_bit(mdl_lfsr, bias) ? weight : 18'sd0;
		if (v > `IZH_V_THRESH)
		begin
			spikes++;
			mdl_v[k] = c;       // reset after the spike
			mdl_u[k] = u + d;
		end
		else
		begin
			prod     = v * v;
			sq       = {prod[35], prod[32:16]};
			// 4v^2 + 6v + 1.4 - u + epsp, wraps at 18 bits
			mdl_v[k] = fix18_t'(4 * sq + 6 * v + `IZH_C14 - u + mdl_epsp[k]);
			diff     = (v >>> shifts[7:4]) - u;
			mdl_u[k] = u + (diff >>> shifts[3:0]);
		end
		mdl_epsp[k] = epsp_step(mdl_epsp[k], i_in, shifts[11:8]);   // old epsp used above
		mdl_lfsr    = lfsr_advance(mdl_lfsr);
	end
endtask

/* verif/izh_tb.sv */
// izhikevich array testbench, axi4-lite register checks and per-sweep spike counts against a model
`timescale 1ns/100ps
`include "izh_config.svh"

module izh_tb;
	import izh_pkg::*;

	localparam int N_TESTS = 4;
	localparam int MAX_SWP = 32;

	logic                   readClock = 1'b0;
	logic                   rst_n;
	logic [`IZH_AXI_AW-1:0] awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [31:0]            wdata;
	logic                   wvalid;
	logic                   wready;
	logic [1:0]             bresp;
	logic                   bvalid;
	logic                   bready;
	logic [`IZH_AXI_AW-1:0] araddr;
	logic                   arvalid;
	logic                   arready;
	logic [31:0]            rdata;
	logic [1:0]             rresp;
	logic                   rvalid;
	logic                   rready;
	logic                   sweep_done;
	logic [`IZH_IDX_W:0]    spike_total;

	// test table, one row per run
	string       tname   [N_TESTS];
	logic [31:0] tbias   [N_TESTS];
	logic [31:0] tweight [N_TESTS];
	logic [31:0] tshifts [N_TESTS];
	logic [31:0] tc      [N_TESTS];
	logic [31:0] td      [N_TESTS];
	int          tsweeps [N_TESTS];
	logic        trerun  [N_TESTS];            // must repeat the row above
	int          run_counts [N_TESTS][MAX_SWP];

	int seed        = 32'h3ece;
	int cycle_count = 0;
	int cycle_limit = 0;

	`include "izh_tb_model.svh"

	izh_array_top u_izh_array_top (
		.readClock(readClock), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.sweep_done(sweep_done), .spike_total(spike_total)
	);

	always #2 readClock = ~readClock;   // 4 ns period

	always @(posedge readClock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation stopped");
		end
	end

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopping at the first error");
		end
	endtask

	//////////////////////////////////////////////////
	// axi4-lite master, called on a falling edge
	task automatic axil_write(input logic [`IZH_AXI_AW-1:0] addr, input logic [31:0] data);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do
			@(negedge readClock);
		while (!awready);
		@(negedge readClock);   // taken on the rising edge just passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge readClock);
		check($sformatf("bresp at 0x%0h", addr), 32'h0, 32'(bresp));   // okay only
	endtask

	task automatic axil_read(input logic [`IZH_AXI_AW-1:0] addr, output logic [31:0] data);
		araddr  = addr;
		arvalid = 1'b1;
		do
			@(negedge readClock);
		while (!arready);
		@(negedge readClock);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge readClock);
		check($sformatf("rresp at 0x%0h", addr), 32'h0, 32'(rresp));
		data = rdata;
	endtask

	task automatic read_expect(input string name, input logic [`IZH_AXI_AW-1:0] addr,
		input logic [31:0] expected);
		logic [31:0] word;
		axil_read(addr, word);
		check(name, expected, word);
	endtask

	// cycles from the call to the next sweep_done
	task automatic wait_sweep(output int cycles);
		cycles = 0;
		do
		begin
			@(negedge readClock);
			cycles++;
		end
		while (!sweep_done);
	endtask

	task automatic set_entry(input int n, input string name, input logic [31:0] bias,
		input logic [31:0] weight, input logic [31:0] shifts, input logic [31:0] c,
		input logic [31:0] d, input int sweeps, input logic rerun);
		tname[n]   = name;
		tbias[n]   = bias;
		tweight[n] = weight;
		tshifts[n] = shifts;
		tc[n]      = c;
		td[n]      = d;
		tsweeps[n] = sweeps;
		trerun[n]  = rerun;
	endtask

	task automatic load_table();
		logic [31:0] rnd;
		logic [31:0] mid;
		rnd = $random(seed);
		mid = 32'h4000 + (rnd & 32'h7fff);   // somewhere in 0x4000..0xbfff
		set_entry(0, "no_drive", 32'h0, 32'h01000, 32'h223, 32'h3599A, 32'h0147A, 20, 1'b0);
		set_entry(1, "full_drive", 32'h10000, 32'h02000, 32'h314, 32'h38000, 32'h02000, 20, 1'b0);
		set_entry(2, "random_bias", mid, 32'h04000, 32'h132, 32'h3599A, 32'h0147A, 24, 1'b0);
		set_entry(3, "rerun", mid, 32'h04000, 32'h132, 32'h3599A, 32'h0147A, 24, 1'b1);
	endtask

	//////////////////////////////////////////////////
	// one table row, init sweep, run, stop, last_spikes
	task automatic run_entry(input int n);
		int gap;
		int expected;
		int last_seen;
		axil_write(5'h04, tbias[n]);
		axil_write(5'h08, tweight[n]);
		axil_write(5'h0C, tshifts[n]);
		axil_write(5'h10, tc[n]);
		axil_write(5'h14, td[n]);
		repeat (20) @(negedge readClock);   // run low, ram refilled with the reset state
		model_reset();
		last_seen = 0;
		axil_write(5'h00, 32'd1);
		for (int s = 0; s < tsweeps[n]; s++)
		begin
			wait_sweep(gap);
			check($sformatf("%s sweep %0d spacing", tname[n], s), (s == 0) ? 17 : 16, gap);
			if (trerun[n])
				expected = run_counts[n-1][s];   // same parameters, same count sequence
			else
				model_sweep(tbias[n][17:0], tweight[n][17:0], tshifts[n], tc[n][17:0],
					td[n][17:0], expected);
			check($sformatf("%s sweep %0d spikes", tname[n], s), expected, 32'(spike_total));
			run_counts[n][s] = expected;
			last_seen        = spike_total;
		end
		axil_write(5'h00, 32'd0);
		// a late pulse is allowed only in the first 17 cycles
		for (int k = 0; k < 37; k++)
		begin
			if (sweep_done)
			begin
				check($sformatf("%s sweep_done %0d cycles after stop", tname[n], k),
					(k < 17) ? 1 : 0, 1);
				last_seen = spike_total;
			end
			@(negedge readClock);
		end
		read_expect($sformatf("%s last_spikes", tname[n]), 5'h18, last_seen);
	endtask

	initial
	begin
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b1;
		load_table();
		for (int n = 0; n < N_TESTS; n++)
			cycle_limit += tsweeps[n] * 16 + 60;
		cycle_limit *= 2;
		repeat (3) @(negedge readClock);
		rst_n = 1'b1;
		@(negedge readClock);

		// reset values
		read_expect("ctrl default", 5'h00, 32'h0);
		read_expect("bias default", 5'h04, 32'h0);
		read_expect("drive_weight default", 5'h08, 32'h01000);
		read_expect("shifts default", 5'h0C, 32'h223);
		read_expect("c default", 5'h10, 32'h3599A);
		read_expect("d default", 5'h14, 32'h0147A);
		read_expect("last_spikes default", 5'h18, 32'h0);

		// readback, bits above each field dropped
		axil_write(5'h04, 32'h2ABCD);
		axil_write(5'h08, 32'h15555);
		axil_write(5'h0C, 32'hFABC);
		axil_write(5'h10, 32'h3F00F);
		axil_write(5'h14, 32'h00ACE);
		axil_write(5'h1C, 32'hFFFF_FFFF);   // hole
		read_expect("bias readback", 5'h04, 32'h2ABCD);
		read_expect("drive_weight readback", 5'h08, 32'h15555);
		read_expect("shifts readback", 5'h0C, 32'hABC);
		read_expect("c readback", 5'h10, 32'h3F00F);
		read_expect("d readback", 5'h14, 32'h00ACE);
		read_expect("unmapped 0x1c", 5'h1C, 32'h0);

		for (int n = 0; n < N_TESTS; n++)
			run_entry(n);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* tb.f */
+incdir+hw
+incdir+verif
hw/izh_pkg.sv
hw/izh_csr.sv
hw/state_ram.sv
hw/poisson_drive.sv
hw/neuron_sweep.sv
hw/izh_update.sv
hw/izh_array_top.sv
verif/izh_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module izh_tb -f tb.f -o izh_tb
	./obj_dir/izh_tb | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
